// File: include/kalman_params.svh
////////////////////
// Kalman filter parameters
// Word format, display width, vector sizes and configuration reset values
////////////////////

`ifndef KALMAN_PARAMS_SVH
`define KALMAN_PARAMS_SVH

// Sign bit, 16 integer bits, 15 fraction bits
`define KALMAN_ARCH_W 32
`define KALMAN_ARCH_F 15

`define KALMAN_DISP_W 11

`define KALMAN_NUM_STATES 4
`define KALMAN_NUM_MEAS 2

// Time step of 1/32 and unit process noise
`define KALMAN_TSTEP_RST 32'd1024
`define KALMAN_QDIAG_RST 32'd32768

`endif

// File: design/kalman_fx_pkg.sv
////////////////////
// Fixed-point types and arithmetic
// Sign-magnitude words, vectors and matrices with add, multiply and negate
////////////////////

`include "kalman_params.svh"

package kalman_fx_pkg;

	typedef logic [`KALMAN_ARCH_W-1:0] fx_t;
	typedef fx_t [`KALMAN_NUM_STATES-1:0] fx_vec_t;
	typedef fx_vec_t [`KALMAN_NUM_STATES-1:0] fx_mat_t;

	localparam fx_t FX_ONE = fx_t'(1) << `KALMAN_ARCH_F;

	// Signs equal add, otherwise larger magnitude wins the sign
	function automatic fx_t fx_add(fx_t a, fx_t b);
		logic [`KALMAN_ARCH_W-2:0] ma;
		logic [`KALMAN_ARCH_W-2:0] mb;
		logic [`KALMAN_ARCH_W-2:0] mag;
		logic sgn;
		ma = a[`KALMAN_ARCH_W-2:0];
		mb = b[`KALMAN_ARCH_W-2:0];
		if (a[`KALMAN_ARCH_W-1] == b[`KALMAN_ARCH_W-1]) begin
			mag = ma + mb;
			sgn = a[`KALMAN_ARCH_W-1];
		end else if (ma >= mb) begin
			mag = ma - mb;
			sgn = a[`KALMAN_ARCH_W-1];
		end else begin
			mag = mb - ma;
			sgn = b[`KALMAN_ARCH_W-1];
		end
		// No negative zero
		if (mag == '0)
			sgn = 1'b0;
		return {sgn, mag};
	endfunction

	// Product truncated back to 15 fraction bits
	function automatic fx_t fx_mul(fx_t a, fx_t b);
		logic [2*`KALMAN_ARCH_W-3:0] prod;
		logic [`KALMAN_ARCH_W-2:0] mag;
		prod = a[`KALMAN_ARCH_W-2:0] * b[`KALMAN_ARCH_W-2:0];
		mag = prod[`KALMAN_ARCH_F +: `KALMAN_ARCH_W-1];
		if (mag == '0)
			return '0;
		return {a[`KALMAN_ARCH_W-1] ^ b[`KALMAN_ARCH_W-1], mag};
	endfunction

	function automatic fx_t fx_neg(fx_t a);
		if (a[`KALMAN_ARCH_W-2:0] == '0)
			return a;
		return {~a[`KALMAN_ARCH_W-1], a[`KALMAN_ARCH_W-2:0]};
	endfunction

	// Constant-velocity transition, time step couples velocity into position
	function automatic fx_mat_t fx_f_mat(fx_t tstep);
		fx_mat_t f;
		f = '0;
		for (int i = 0; i < `KALMAN_NUM_STATES; i++)
			f[i][i] = FX_ONE;
		f[0][2] = tstep;
		f[1][3] = tstep;
		return f;
	endfunction

endpackage

// File: design/kalman_ctrl_pkg.sv
////////////////////
// Kalman control types
// Sequencer phases and configuration register map
////////////////////

package kalman_ctrl_pkg;

	typedef enum logic [2:0] {
		PH_INIT      = 3'd0,
		PH_IDLE      = 3'd1,
		PH_PREDICT_1 = 3'd2,
		PH_PREDICT_2 = 3'd3,
		PH_INNOV     = 3'd4,
		PH_UPDATE    = 3'd5
	} phase_e;

	typedef enum logic [0:0] {
		CFG_TSTEP = 1'b0,
		CFG_QDIAG = 1'b1
	} cfg_addr_e;

endpackage

// File: design/kalman_pos_if.sv
////////////////////
// Position interface
// Predicted and current x/y positions from the state predictor
////////////////////

`timescale 1ns/1ps

interface kalman_pos_if;

	kalman_fx_pkg::fx_t x_pred_x;
	kalman_fx_pkg::fx_t x_pred_y;
	kalman_fx_pkg::fx_t x_curr_x;
	kalman_fx_pkg::fx_t x_curr_y;

	modport src (output x_pred_x, output x_pred_y, output x_curr_x, output x_curr_y);

	// Innovation only needs the predictions
	modport sink (input x_pred_x, input x_pred_y);

endinterface

// File: design/kalman_ctrl.sv
////////////////////
// Kalman sequencer
// Accepts a measurement and walks the filter through one update
////////////////////

`timescale 1ns/1ps

module kalman_ctrl (
	input  logic                    clk,
	input  logic                    aresetn,
	input  logic                    i_valid,
	output logic                    o_ready,
	output kalman_ctrl_pkg::phase_e o_phase
);

	kalman_ctrl_pkg::phase_e phase_next;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn)
			o_phase <= kalman_ctrl_pkg::PH_INIT;
		else
			o_phase <= phase_next;
	end

	// Fixed walk, only IDLE waits
	always_comb begin
		case (o_phase)
			kalman_ctrl_pkg::PH_INIT:
				phase_next = kalman_ctrl_pkg::PH_IDLE;
			kalman_ctrl_pkg::PH_IDLE:
				phase_next = i_valid ? kalman_ctrl_pkg::PH_PREDICT_1 : kalman_ctrl_pkg::PH_IDLE;
			kalman_ctrl_pkg::PH_PREDICT_1:
				phase_next = kalman_ctrl_pkg::PH_PREDICT_2;
			kalman_ctrl_pkg::PH_PREDICT_2:
				phase_next = kalman_ctrl_pkg::PH_INNOV;
			kalman_ctrl_pkg::PH_INNOV:
				phase_next = kalman_ctrl_pkg::PH_UPDATE;
			kalman_ctrl_pkg::PH_UPDATE:
				phase_next = kalman_ctrl_pkg::PH_IDLE;
			default:
				phase_next = kalman_ctrl_pkg::PH_INIT;
		endcase
	end

	assign o_ready = (o_phase == kalman_ctrl_pkg::PH_IDLE);

endmodule

// File: design/kalman_cfg.sv
////////////////////
// Kalman configuration registers
// Run-time time step and process-noise diagonal
////////////////////

`timescale 1ns/1ps

`include "kalman_params.svh"

module kalman_cfg (
	input  logic                       clk,
	input  logic                       aresetn,
	input  logic                       i_cfg_we,
	input  kalman_ctrl_pkg::cfg_addr_e i_cfg_addr,
	input  kalman_fx_pkg::fx_t         i_cfg_wdata,
	output kalman_fx_pkg::fx_t         o_tstep,
	output kalman_fx_pkg::fx_t         o_q_diag
);

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			o_tstep <= `KALMAN_TSTEP_RST;
			o_q_diag <= `KALMAN_QDIAG_RST;
		end else if (i_cfg_we) begin
			// Single-cycle write, no handshake
			case (i_cfg_addr)
				kalman_ctrl_pkg::CFG_TSTEP:
					o_tstep <= i_cfg_wdata;
				kalman_ctrl_pkg::CFG_QDIAG:
					o_q_diag <= i_cfg_wdata;
			endcase
		end
	end

endmodule

// File: design/kalman_state_pred.sv
////////////////////
// State predictor
// Holds the state vector, forms F*x and commits it on update
////////////////////

`timescale 1ns/1ps

`include "kalman_params.svh"

module kalman_state_pred (
	input  logic                    clk,
	input  logic                    aresetn,
	input  kalman_ctrl_pkg::phase_e i_phase,
	input  kalman_fx_pkg::fx_t      i_tstep,
	kalman_pos_if.src               pos
);

	kalman_fx_pkg::fx_mat_t f_mat;
	kalman_fx_pkg::fx_vec_t x_curr;
	kalman_fx_pkg::fx_vec_t x_pred;
	kalman_fx_pkg::fx_vec_t x_prod;

	assign f_mat = kalman_fx_pkg::fx_f_mat(i_tstep);

	// Row by row dot product with x_curr
	always_comb begin
		kalman_fx_pkg::fx_t acc;
		for (int i = 0; i < `KALMAN_NUM_STATES; i++) begin
			acc = kalman_fx_pkg::fx_mul(f_mat[i][0], x_curr[0]);
			for (int k = 1; k < `KALMAN_NUM_STATES; k++)
				acc = kalman_fx_pkg::fx_add(acc, kalman_fx_pkg::fx_mul(f_mat[i][k], x_curr[k]));
			x_prod[i] = acc;
		end
	end

	always_ff @(posedge clk) begin
		if (i_phase == kalman_ctrl_pkg::PH_PREDICT_1)
			x_pred <= x_prod;
	end

	////////////////////
	// Current state
	////////////////////

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			x_curr <= {`KALMAN_NUM_STATES{kalman_fx_pkg::FX_ONE}};
		end else if (i_phase == kalman_ctrl_pkg::PH_INIT) begin
			// Every element starts at 1.0
			x_curr <= {`KALMAN_NUM_STATES{kalman_fx_pkg::FX_ONE}};
		end else if (i_phase == kalman_ctrl_pkg::PH_UPDATE) begin
			x_curr <= x_pred;
		end
	end

	// Rows 0 and 1 are the positions
	assign pos.x_pred_x = x_pred[0];
	assign pos.x_pred_y = x_pred[1];
	assign pos.x_curr_x = x_curr[0];
	assign pos.x_curr_y = x_curr[1];

endmodule

// File: design/kalman_cov_pred.sv
////////////////////
// Covariance predictor
// Two-stage F*P*F' + Q with commit of the predicted covariance
////////////////////

`timescale 1ns/1ps

`include "kalman_params.svh"

module kalman_cov_pred (
	input  logic                    clk,
	input  logic                    aresetn,
	input  kalman_ctrl_pkg::phase_e i_phase,
	input  kalman_fx_pkg::fx_t      i_tstep,
	input  kalman_fx_pkg::fx_t      i_q_diag,
	output kalman_fx_pkg::fx_t      o_var_x,
	output kalman_fx_pkg::fx_t      o_var_y
);

	kalman_fx_pkg::fx_mat_t f_mat;
	kalman_fx_pkg::fx_mat_t p_curr;
	kalman_fx_pkg::fx_mat_t p_init;
	kalman_fx_pkg::fx_mat_t fp;
	kalman_fx_pkg::fx_mat_t fp_prod;
	kalman_fx_pkg::fx_mat_t p_pred;
	kalman_fx_pkg::fx_mat_t p_prod;

	assign f_mat = kalman_fx_pkg::fx_f_mat(i_tstep);

	// Identity
	always_comb begin
		p_init = '0;
		for (int i = 0; i < `KALMAN_NUM_STATES; i++)
			p_init[i][i] = kalman_fx_pkg::FX_ONE;
	end

	////////////////////
	// Stage 1, F*P
	////////////////////

	always_comb begin
		kalman_fx_pkg::fx_t acc;
		for (int i = 0; i < `KALMAN_NUM_STATES; i++) begin
			for (int j = 0; j < `KALMAN_NUM_STATES; j++) begin
				acc = kalman_fx_pkg::fx_mul(f_mat[i][0], p_curr[0][j]);
				for (int k = 1; k < `KALMAN_NUM_STATES; k++)
					acc = kalman_fx_pkg::fx_add(acc,
						kalman_fx_pkg::fx_mul(f_mat[i][k], p_curr[k][j]));
				fp_prod[i][j] = acc;
			end
		end
	end

	////////////////////
	// Stage 2, (F*P)*F' + Q
	////////////////////

	always_comb begin
		kalman_fx_pkg::fx_t acc;
		for (int i = 0; i < `KALMAN_NUM_STATES; i++) begin
			for (int j = 0; j < `KALMAN_NUM_STATES; j++) begin
				// Transpose by indexing F as [j][k]
				acc = kalman_fx_pkg::fx_mul(fp[i][0], f_mat[j][0]);
				for (int k = 1; k < `KALMAN_NUM_STATES; k++)
					acc = kalman_fx_pkg::fx_add(acc, kalman_fx_pkg::fx_mul(fp[i][k], f_mat[j][k]));
				if (i == j)
					acc = kalman_fx_pkg::fx_add(acc, i_q_diag);
				p_prod[i][j] = acc;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_phase == kalman_ctrl_pkg::PH_PREDICT_1)
			fp <= fp_prod;
		if (i_phase == kalman_ctrl_pkg::PH_PREDICT_2)
			p_pred <= p_prod;
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn)
			p_curr <= p_init;
		else if (i_phase == kalman_ctrl_pkg::PH_INIT)
			p_curr <= p_init;
		else if (i_phase == kalman_ctrl_pkg::PH_UPDATE)
			p_curr <= p_pred;
	end

	// Position variances
	assign o_var_x = p_curr[0][0];
	assign o_var_y = p_curr[1][1];

endmodule

// File: design/kalman_innov.sv
////////////////////
// Innovation stage
// Latches the measurement and forms measurement minus predicted position
////////////////////

`timescale 1ns/1ps

`include "kalman_params.svh"

module kalman_innov (
	input  logic                     clk,
	input  logic                     aresetn,
	input  logic                     i_valid,
	input  logic                     i_ready,
	input  logic [`KALMAN_DISP_W-1:0] i_z_x,
	input  logic [`KALMAN_DISP_W-1:0] i_z_y,
	input  kalman_ctrl_pkg::phase_e  i_phase,
	kalman_pos_if.sink               pos,
	output kalman_fx_pkg::fx_t       o_innov_x,
	output kalman_fx_pkg::fx_t       o_innov_y
);

	kalman_fx_pkg::fx_t z_fx [`KALMAN_NUM_MEAS];
	kalman_fx_pkg::fx_t y_sub [`KALMAN_NUM_MEAS];

	// Whole units, positive sign
	always_ff @(posedge clk) begin
		if (i_valid && i_ready) begin
			z_fx[0] <= kalman_fx_pkg::fx_t'(i_z_x) << `KALMAN_ARCH_F;
			z_fx[1] <= kalman_fx_pkg::fx_t'(i_z_y) << `KALMAN_ARCH_F;
		end
	end

	// Subtract by adding the negated prediction
	assign y_sub[0] = kalman_fx_pkg::fx_add(z_fx[0], kalman_fx_pkg::fx_neg(pos.x_pred_x));
	assign y_sub[1] = kalman_fx_pkg::fx_add(z_fx[1], kalman_fx_pkg::fx_neg(pos.x_pred_y));

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			o_innov_x <= '0;
			o_innov_y <= '0;
		end else if (i_phase == kalman_ctrl_pkg::PH_INNOV) begin
			o_innov_x <= y_sub[0];
			o_innov_y <= y_sub[1];
		end
	end

endmodule

// File: design/kalman_top.sv
////////////////////
// Kalman filter top
// Prediction half of a constant-velocity filter with run-time configuration
////////////////////

`timescale 1ns/1ps

`include "kalman_params.svh"

module kalman_top (
	input  logic                      clk,
	input  logic                      aresetn,
	input  logic [`KALMAN_DISP_W-1:0] i_z_x,
	input  logic [`KALMAN_DISP_W-1:0] i_z_y,
	input  logic                      i_valid,
	output logic                      o_ready,
	input  logic                      i_cfg_we,
	input  logic                      i_cfg_addr,
	input  logic [`KALMAN_ARCH_W-1:0] i_cfg_wdata,
	output logic [`KALMAN_DISP_W-1:0] o_z_x_new,
	output logic [`KALMAN_DISP_W-1:0] o_z_y_new,
	output logic [`KALMAN_ARCH_W-1:0] o_innov_x,
	output logic [`KALMAN_ARCH_W-1:0] o_innov_y,
	output logic [`KALMAN_ARCH_W-1:0] o_var_x,
	output logic [`KALMAN_ARCH_W-1:0] o_var_y,
	output logic                      o_upd
);

	kalman_ctrl_pkg::phase_e phase;
	kalman_fx_pkg::fx_t tstep;
	kalman_fx_pkg::fx_t q_diag;

	kalman_pos_if pos_if ();

	kalman_ctrl kalman_ctrl_i (
		.clk     (clk),
		.aresetn (aresetn),
		.i_valid (i_valid),
		.o_ready (o_ready),
		.o_phase (phase)
	);

	kalman_cfg kalman_cfg_i (
		.clk         (clk),
		.aresetn     (aresetn),
		.i_cfg_we    (i_cfg_we),
		.i_cfg_addr  (kalman_ctrl_pkg::cfg_addr_e'(i_cfg_addr)),
		.i_cfg_wdata (i_cfg_wdata),
		.o_tstep     (tstep),
		.o_q_diag    (q_diag)
	);

	kalman_state_pred kalman_state_pred_i (
		.clk     (clk),
		.aresetn (aresetn),
		.i_phase (phase),
		.i_tstep (tstep),
		.pos     (pos_if.src)
	);

	kalman_cov_pred kalman_cov_pred_i (
		.clk      (clk),
		.aresetn  (aresetn),
		.i_phase  (phase),
		.i_tstep  (tstep),
		.i_q_diag (q_diag),
		.o_var_x  (o_var_x),
		.o_var_y  (o_var_y)
	);

	kalman_innov kalman_innov_i (
		.clk       (clk),
		.aresetn   (aresetn),
		.i_valid   (i_valid),
		.i_ready   (o_ready),
		.i_z_x     (i_z_x),
		.i_z_y     (i_z_y),
		.i_phase   (phase),
		.pos       (pos_if.sink),
		.o_innov_x (o_innov_x),
		.o_innov_y (o_innov_y)
	);

	// High on the cycle the committed state first shows
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn)
			o_upd <= 1'b0;
		else
			o_upd <= (phase == kalman_ctrl_pkg::PH_UPDATE);
	end

	// Integer part of the current position
	assign o_z_x_new = pos_if.x_curr_x[`KALMAN_ARCH_F +: `KALMAN_DISP_W];
	assign o_z_y_new = pos_if.x_curr_y[`KALMAN_ARCH_F +: `KALMAN_DISP_W];

endmodule

// File: verif/kalman_properties.sv
////////////////////
// Kalman handshake properties
// Busy window, update latency and pulse qualification
////////////////////

`timescale 1ns/1ps

module kalman_properties (
	input logic clk,
	input logic aresetn,
	input logic i_valid,
	input logic o_ready,
	input logic o_upd
);

	logic accept;

	assign accept = i_valid && o_ready;

	// Four busy cycles after the accepting edge
	busy_after_accept: assert property (@(posedge clk) disable iff (!aresetn)
		($past(accept, 1) || $past(accept, 2) || $past(accept, 3) || $past(accept, 4))
		|-> !o_ready)
		else $error("o_ready rose during the update of an accepted measurement");

	// Pulse shows at the fifth sample after the accept, four clocks on
	upd_latency: assert property (@(posedge clk) disable iff (!aresetn)
		o_upd == $past(accept, 5))
		else $error("o_upd did not follow an accept by exactly four cycles");

	upd_when_ready: assert property (@(posedge clk) disable iff (!aresetn)
		o_upd |-> o_ready)
		else $error("o_upd high while o_ready low");

endmodule

bind kalman_top kalman_properties kalman_properties_i (
	.clk     (clk),
	.aresetn (aresetn),
	.i_valid (i_valid),
	.o_ready (o_ready),
	.o_upd   (o_upd)
);

// File: verif/kalman_tb.sv
////////////////////
// Kalman filter testbench
// Directed tests against a fixed-point model of the prediction path
////////////////////

`timescale 1ns/1ps

`include "kalman_params.svh"

module kalman_tb;

	// Whole run is about 150 cycles, limit is well over ten times that
	localparam int TIMEOUT_CYCLES = 2000;
	localparam logic [31:0] ONE_REF = 32'd1 << `KALMAN_ARCH_F;

	logic clk;
	logic aresetn;
	logic [`KALMAN_DISP_W-1:0] i_z_x;
	logic [`KALMAN_DISP_W-1:0] i_z_y;
	logic i_valid;
	logic o_ready;
	logic i_cfg_we;
	logic i_cfg_addr;
	logic [`KALMAN_ARCH_W-1:0] i_cfg_wdata;
	logic [`KALMAN_DISP_W-1:0] o_z_x_new;
	logic [`KALMAN_DISP_W-1:0] o_z_y_new;
	logic [`KALMAN_ARCH_W-1:0] o_innov_x;
	logic [`KALMAN_ARCH_W-1:0] o_innov_y;
	logic [`KALMAN_ARCH_W-1:0] o_var_x;
	logic [`KALMAN_ARCH_W-1:0] o_var_y;
	logic o_upd;

	int errors;
	int cycle_cnt;
	int seed_val;
	bit verdict_done;

	// Model state as signed values in units of 2^-15
	longint m_x [4];
	longint m_p [4][4];
	longint m_tstep;
	longint m_q;
	longint exp_innov_x;
	longint exp_innov_y;

	kalman_top kalman_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		verdict_done = 1'b1;
		$display("Timeout after %0d cycles, the DUT never finished the tests", cycle_cnt);
		$display("** FAIL **");
		$finish;
	end

	final begin
		if (!verdict_done)
			$display("** FAIL **");
	end

	////////////////////
	// Reference model
	////////////////////

	function automatic longint from_fx(logic [31:0] v);
		longint mag;
		mag = longint'(v[30:0]);
		return v[31] ? -mag : mag;
	endfunction

	function automatic logic [31:0] to_fx(longint v);
		if (v < 0)
			return {1'b1, 31'(-v)};
		return {1'b0, 31'(v)};
	endfunction

	// Magnitude product truncated to 15 fraction bits, zero stays positive
	function automatic longint scaled_mul(longint a, longint b);
		longint ma;
		longint mb;
		longint m;
		ma = (a < 0) ? -a : a;
		mb = (b < 0) ? -b : b;
		m = (ma * mb) >> 15;
		if (m == 0)
			return 0;
		return ((a < 0) != (b < 0)) ? -m : m;
	endfunction

	function automatic longint f_entry(int i, int k);
		if (i == k)
			return longint'(ONE_REF);
		if ((i == 0 && k == 2) || (i == 1 && k == 3))
			return m_tstep;
		return 0;
	endfunction

	function automatic void model_update(logic [10:0] zx, logic [10:0] zy);
		longint xp [4];
		longint fp [4][4];
		longint pp [4][4];
		for (int i = 0; i < 4; i++) begin
			xp[i] = 0;
			for (int k = 0; k < 4; k++)
				xp[i] += scaled_mul(f_entry(i, k), m_x[k]);
			for (int j = 0; j < 4; j++) begin
				fp[i][j] = 0;
				for (int k = 0; k < 4; k++)
					fp[i][j] += scaled_mul(f_entry(i, k), m_p[k][j]);
			end
		end
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				pp[i][j] = (i == j) ? m_q : 0;
				for (int k = 0; k < 4; k++)
					pp[i][j] += scaled_mul(fp[i][k], f_entry(j, k));
			end
		end
		exp_innov_x = (longint'(zx) << 15) - xp[0];
		exp_innov_y = (longint'(zy) << 15) - xp[1];
		for (int i = 0; i < 4; i++) begin
			m_x[i] = xp[i];
			for (int j = 0; j < 4; j++)
				m_p[i][j] = pp[i][j];
		end
	endfunction

	////////////////////
	// Helpers
	////////////////////

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic wait_ready();
		while (!o_ready)
			tick();
	endtask

	task automatic compare_word(input string test, input string what,
		input logic [31:0] exp_val, input logic [31:0] act_val);
		assert (act_val === exp_val) else begin
			$display("[ERROR] %s: %s expected %h, actual %h", test, what, exp_val, act_val);
			errors++;
		end
	endtask

	task automatic verify_outputs(input string test);
		compare_word(test, "o_z_x_new", 32'(11'(m_x[0] >> 15)), 32'(o_z_x_new));
		compare_word(test, "o_z_y_new", 32'(11'(m_x[1] >> 15)), 32'(o_z_y_new));
		compare_word(test, "o_innov_x", to_fx(exp_innov_x), o_innov_x);
		compare_word(test, "o_innov_y", to_fx(exp_innov_y), o_innov_y);
		compare_word(test, "o_var_x", to_fx(m_p[0][0]), o_var_x);
		compare_word(test, "o_var_y", to_fx(m_p[1][1]), o_var_y);
	endtask

	// One accepting edge, then count cycles up to the update pulse
	task automatic send_meas(input string test, input logic [10:0] zx, input logic [10:0] zy);
		int lat;
		wait_ready();
		i_valid = 1'b1;
		i_z_x = zx;
		i_z_y = zy;
		tick();
		i_valid = 1'b0;
		model_update(zx, zy);
		lat = 0;
		while (!o_upd) begin
			tick();
			lat++;
		end
		compare_word(test, "o_upd latency", 32'd4, 32'(lat));
		verify_outputs(test);
	endtask

	task automatic write_cfg(input logic addr, input logic [31:0] data);
		wait_ready();
		i_cfg_we = 1'b1;
		i_cfg_addr = addr;
		i_cfg_wdata = data;
		tick();
		i_cfg_we = 1'b0;
		if (addr == 1'b0)
			m_tstep = from_fx(data);
		else
			m_q = from_fx(data);
	endtask

	////////////////////
	// Tests
	////////////////////

	// Still in PH_INIT right after release, ready one edge later
	task automatic reset_state_test();
		compare_word("reset", "o_ready in PH_INIT", 32'd0, 32'(o_ready));
		compare_word("reset", "o_upd in PH_INIT", 32'd0, 32'(o_upd));
		tick();
		compare_word("reset", "o_ready", 32'd1, 32'(o_ready));
		compare_word("reset", "o_z_x_new", 32'd1, 32'(o_z_x_new));
		compare_word("reset", "o_z_y_new", 32'd1, 32'(o_z_y_new));
		compare_word("reset", "o_var_x", ONE_REF, o_var_x);
		compare_word("reset", "o_var_y", ONE_REF, o_var_y);
	endtask

	task automatic single_prediction_test();
		send_meas("single", 11'd100, 11'd37);
		compare_word("single", "position integer x", 32'd1, 32'(o_z_x_new));
		compare_word("single", "position integer y", 32'd1, 32'(o_z_y_new));
	endtask

	task automatic covariance_growth_test();
		for (int n = 0; n < 10; n++)
			send_meas("cov_growth", 11'($urandom), 11'($urandom));
	endtask

	task automatic config_test();
		write_cfg(1'b0, ONE_REF >> 1);
		write_cfg(1'b1, ONE_REF >> 2);
		send_meas("config", 11'd5, 11'd2000);
		send_meas("config", 11'd0, 11'd3);
		send_meas("config", 11'($urandom), 11'($urandom));
	endtask

	// i_valid stays high while the data changes every cycle
	task automatic backpressure_test();
		int accepts;
		int pulses;
		logic [10:0] zx;
		logic [10:0] zy;
		accepts = 0;
		pulses = 0;
		wait_ready();
		repeat (24) begin
			zx = 11'($urandom);
			zy = 11'($urandom);
			i_valid = 1'b1;
			i_z_x = zx;
			i_z_y = zy;
			if (o_ready) begin
				model_update(zx, zy);
				accepts++;
			end
			tick();
			if (o_upd) begin
				pulses++;
				verify_outputs("backpressure");
			end
		end
		i_valid = 1'b0;
		while (pulses < accepts) begin
			tick();
			if (o_upd) begin
				pulses++;
				verify_outputs("backpressure");
			end
		end
		compare_word("backpressure", "o_upd pulses", 32'(accepts), 32'(pulses));
	endtask

	initial begin
		seed_val = $urandom(32'ha9b1);
		errors = 0;
		verdict_done = 1'b0;
		aresetn = 1'b0;
		i_z_x = '0;
		i_z_y = '0;
		i_valid = 1'b0;
		i_cfg_we = 1'b0;
		i_cfg_addr = 1'b0;
		i_cfg_wdata = '0;
		// State of 1.0 everywhere, identity covariance
		for (int i = 0; i < 4; i++) begin
			m_x[i] = longint'(ONE_REF);
			for (int j = 0; j < 4; j++)
				m_p[i][j] = (i == j) ? longint'(ONE_REF) : 0;
		end
		m_tstep = longint'(`KALMAN_TSTEP_RST);
		m_q = longint'(`KALMAN_QDIAG_RST);
		repeat (3) @(posedge clk);
		#2;
		aresetn = 1'b1;
		reset_state_test();
		single_prediction_test();
		covariance_growth_test();
		config_test();
		backpressure_test();
		verdict_done = 1'b1;
		$display("Tests complete, %0d errors", errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: flist.f
+incdir+include
design/kalman_fx_pkg.sv
design/kalman_ctrl_pkg.sv
design/kalman_pos_if.sv
design/kalman_ctrl.sv
design/kalman_cfg.sv
design/kalman_state_pred.sv
design/kalman_cov_pred.sv
design/kalman_innov.sv
design/kalman_top.sv
verif/kalman_properties.sv
verif/kalman_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the Kalman testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module kalman_tb \
	-Mdir obj_dir -o kalman_sim > build.log 2>&1 \
	&& ./obj_dir/kalman_sim > sim.log 2>&1

grep -qx '\*\* PASS \*\*' sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see build.log and sim.log"; exit 1; }
